// File: hw/fe_pkg.sv
package fe_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int WORD_W      = 16;    // Data bus and register width
    localparam int ADDR_W      = 20;    // Physical address space
    localparam int QUEUE_BYTES = 6;     // Instruction queue depth

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] paddr_t;
    typedef logic [2:0]        len_t;   // Instruction length, 1..6

    // Front end sequencing
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        READ_DATA,
        READ_DATA_WIDE,
        ISSUE
    } fe_state_t;

    typedef enum logic [2:0] {
        SEG_ES = 3'd0,
        SEG_CS = 3'd1,
        SEG_SS = 3'd2,
        SEG_DS = 3'd3,
        SEG_FS = 3'd4,
        SEG_GS = 3'd5
    } seg_sel_t;

    // 0..7 AX CX DX BX SP BP SI DI, 8..13 ES CS SS DS FS GS
    typedef logic [3:0] reg_idx_t;

    localparam word_t DEF_RESET_CS = 16'hFFFF;
    localparam word_t DEF_RESET_IP = 16'h0000;

    // Segment * 16 + offset, wraps at 1 MB
    function automatic paddr_t phys_addr(word_t seg, word_t off);
        return {seg, 4'h0} + ADDR_W'(off);
    endfunction

endpackage

// File: hw/decode_if.sv
`timescale 1ns/1ps

interface decode_if;
    import fe_pkg::*;

    logic       has_prefix;     // Head byte is a prefix
    logic       has_modrm;      // Opcode carries a ModRM byte
    len_t       length;         // Bytes dropped from the queue on DECODE
    logic [7:0] modrm;          // Byte after the opcode
    logic       is_override;    // Prefix names a segment
    seg_sel_t   override_sel;

    // Driven by the decoder
    modport dec (
        output has_prefix, has_modrm, length, modrm, is_override, override_sel
    );

    // FSM and operand unit side
    modport user (
        input has_prefix, has_modrm, length, modrm, is_override, override_sel
    );

endinterface

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter fe_pkg::word_t RESET_CS = fe_pkg::DEF_RESET_CS
) (
    input  logic             clock,
    input  logic             i_rst_n,
    input  logic             i_we,          // Execute stage write port
    input  fe_pkg::reg_idx_t i_sel,
    input  fe_pkg::word_t    i_wdata,
    output fe_pkg::word_t    o_gpr [8],     // AX CX DX BX SP BP SI DI
    output fe_pkg::word_t    o_seg [6]      // ES CS SS DS FS GS
);
    import fe_pkg::*;

    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 8; i++) begin
                o_gpr[i] <= '0;
            end
            // Only CS comes up non-zero
            for (int i = 0; i < 6; i++) begin
                o_seg[i] <= (i == SEG_CS) ? RESET_CS : '0;
            end
        end else if (i_we) begin
            if (!i_sel[3]) begin
                o_gpr[i_sel[2:0]] <= i_wdata;       // General register
            end else if (i_sel[2:0] < 3'd6) begin
                o_seg[i_sel[2:0]] <= i_wdata;       // Segment, 14 and 15 unmapped
            end
        end
    end

endmodule

// File: hw/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue (
    input  logic                             clock,
    input  logic                             i_rst_n,
    input  logic                             i_load,        // Take bytes from the bus
    input  logic                             i_shift,       // Drop decoded instruction
    input  fe_pkg::len_t                     i_length,
    input  fe_pkg::word_t                    i_refill_ptr,
    input  fe_pkg::word_t                    i_cs,
    input  fe_pkg::word_t                    i_data,
    output logic [8*fe_pkg::QUEUE_BYTES-1:0] o_queue,
    output logic                             o_full,
    output fe_pkg::paddr_t                   o_fetch_addr
);
    import fe_pkg::*;

    logic [2:0] fill;           // Bytes held, 0..6
    word_t      ptr;            // Offset of next byte to fetch
    logic       ptr_valid;
    word_t      cur_ptr;
    logic       odd;

    // Before the first shift the pointer follows IP from the FSM
    assign cur_ptr      = ptr_valid ? ptr : i_refill_ptr;
    assign odd          = cur_ptr[0];
    assign o_full       = (fill == 3'(QUEUE_BYTES));
    assign o_fetch_addr = phys_addr(i_cs, cur_ptr);

    // ----------------------------------------
    // Fill counter and pointer
    // ----------------------------------------
    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fill      <= '0;
            ptr       <= '0;
            ptr_valid <= 1'b0;
        end else if (i_shift) begin
            fill      <= 3'(QUEUE_BYTES) - i_length;   // Bytes left behind
            ptr       <= i_refill_ptr;
            ptr_valid <= 1'b1;
        end else if (i_load) begin
            // Odd address or last free slot takes one byte
            if (odd || fill == 3'(QUEUE_BYTES - 1)) begin
                fill <= fill + 3'd1;
                ptr  <= cur_ptr + 16'd1;
            end else begin
                fill <= fill + 3'd2;
                ptr  <= cur_ptr + 16'd2;
            end
            ptr_valid <= 1'b1;
        end
    end

    // Queue bytes, byte 0 is the head
    always_ff @(posedge clock) begin
        if (i_shift) begin
            o_queue <= o_queue >> {i_length, 3'b000};
        end else if (i_load) begin
            if (odd) begin
                o_queue[8*fill +: 8] <= i_data[15:8];  // Odd byte sits on the high lane
            end else begin
                o_queue[8*fill +: 8] <= i_data[7:0];
                if (fill < 3'(QUEUE_BYTES - 1)) begin
                    o_queue[8*fill + 8 +: 8] <= i_data[15:8];
                end
            end
        end
    end

endmodule

// File: hw/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder (
    input  logic [8*fe_pkg::QUEUE_BYTES-1:0] i_queue,
    decode_if.dec                            dec
);
    import fe_pkg::*;

    logic [7:0] opcode;
    logic [7:0] modrm;
    len_t       modrm_len;      // Opcode + ModRM + displacement

    assign opcode    = i_queue[7:0];
    assign modrm     = i_queue[15:8];
    assign dec.modrm = modrm;

    always_comb begin
        // Prefix bytes
        casez (opcode)
            8'b001?_?110,                           // ES CS SS DS
            8'b0110_01??,                           // FS GS, size prefixes
            8'h9B,                                  // WAIT
            8'hF0,                                  // LOCK
            8'b1111_001?: dec.has_prefix = 1'b1;    // REPNZ REP
            default:      dec.has_prefix = 1'b0;
        endcase

        // One-byte opcode map, 0F has no ModRM
        casez (opcode)
            8'b00??_?0??,                           // ALU r/m forms
            8'b1000_????,                           // 80-8F
            8'b1100_000?,                           // C0-C1
            8'b1100_01??,                           // C4-C7
            8'b1101_00??,                           // D0-D3 shifts
            8'b1101_1???,                           // D8-DF escape
            8'b1111_?11?: dec.has_modrm = 1'b1;     // F6-F7 FE-FF groups
            default:      dec.has_modrm = 1'b0;
        endcase

        case (modrm[7:6])
            2'b00:   modrm_len = (modrm[2:0] == 3'b110) ? 3'd4 : 3'd2;  // disp16 direct
            2'b01:   modrm_len = 3'd3;                                  // disp8
            2'b10:   modrm_len = 3'd4;                                  // disp16
            default: modrm_len = 3'd2;                                  // Register form
        endcase

        if (dec.has_prefix) begin
            dec.length = 3'd1;
        end else if (dec.has_modrm) begin
            // Immediate groups add w + 1 bytes
            casez (opcode)
                8'b1000_00??,
                8'b1100_011?: dec.length = modrm_len + 3'(opcode[0]) + 3'd1;
                default:      dec.length = modrm_len;
            endcase
        end else begin
            dec.length = 3'd1;
        end

        // Segment straight from the prefix byte
        dec.is_override  = 1'b0;
        dec.override_sel = SEG_DS;
        casez (opcode)
            8'b001?_?110: begin
                dec.is_override  = 1'b1;
                dec.override_sel = seg_sel_t'({1'b0, opcode[4:3]});
            end
            8'b0110_010?: begin
                dec.is_override  = 1'b1;
                dec.override_sel = seg_sel_t'({2'b10, opcode[0]});
            end
            default: ;
        endcase
    end

endmodule

// File: hw/operand_unit.sv
`timescale 1ns/1ps

module operand_unit (
    input  logic                             clock,
    input  logic                             i_rst_n,
    input  fe_pkg::word_t                    i_gpr [8],
    input  fe_pkg::word_t                    i_seg [6],
    input  logic                             i_override,
    input  fe_pkg::seg_sel_t                 i_override_sel,
    input  logic [8*fe_pkg::QUEUE_BYTES-1:0] i_queue,
    input  logic                             i_latch,
    input  logic                             i_capture_lo,
    input  logic                             i_capture_hi,
    input  fe_pkg::word_t                    i_data,
    decode_if.user                           dec,
    output fe_pkg::paddr_t                   o_data_addr,
    output logic                             o_need_wide,
    output fe_pkg::word_t                    o_op1,
    output fe_pkg::word_t                    o_op2
);
    import fe_pkg::*;

    logic [1:0] mod;
    logic [2:0] rm;
    logic       w_bit;
    logic       d_bit;
    word_t      disp16;
    word_t      base;
    word_t      ea;
    seg_sel_t   seg_sel;
    word_t      a_reg;          // r/m operand
    word_t      b_reg;          // reg operand
    word_t      seg_q;
    word_t      off_q;
    logic       w_q;
    logic       d_q;

    assign mod    = dec.modrm[7:6];
    assign rm     = dec.modrm[2:0];
    assign w_bit  = i_queue[0];
    assign d_bit  = i_queue[1];
    assign disp16 = i_queue[31:16];

    // Byte indices 4..7 are AH CH DH BH
    function automatic word_t pick_reg(logic [2:0] idx, logic w);
        if (w) begin
            return i_gpr[idx];
        end
        return idx[2] ? {8'h00, i_gpr[idx[1:0]][15:8]} : {8'h00, i_gpr[idx[1:0]][7:0]};
    endfunction

    // ----------------------------------------
    // Effective address
    // ----------------------------------------
    always_comb begin
        case (rm)
            3'd0:    base = i_gpr[3] + i_gpr[6];                // bx+si
            3'd1:    base = i_gpr[3] + i_gpr[7];                // bx+di
            3'd2:    base = i_gpr[5] + i_gpr[6];                // bp+si
            3'd3:    base = i_gpr[5] + i_gpr[7];                // bp+di
            3'd4:    base = i_gpr[6];
            3'd5:    base = i_gpr[7];
            3'd6:    base = (mod == 2'b00) ? disp16 : i_gpr[5]; // Direct or bp
            default: base = i_gpr[3];
        endcase
        case (mod)
            2'b01:   ea = base + {{8{i_queue[23]}}, i_queue[23:16]};
            2'b10:   ea = base + disp16;
            default: ea = base;
        endcase
        // bp forms default to the stack segment
        if (rm == 3'd2 || rm == 3'd3 || (rm == 3'd6 && mod != 2'b00)) begin
            seg_sel = SEG_SS;
        end else begin
            seg_sel = SEG_DS;
        end
        if (i_override) begin
            seg_sel = i_override_sel;
        end
    end

    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            w_q <= 1'b0;
            d_q <= 1'b0;
        end else if (i_latch) begin
            w_q <= w_bit;
            d_q <= d_bit;
        end
    end

    // ----------------------------------------
    // Operand latch and memory capture
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (i_latch) begin
            a_reg <= pick_reg(rm, w_bit);
            b_reg <= pick_reg(dec.modrm[5:3], w_bit);
            seg_q <= i_seg[seg_sel];
            off_q <= ea;
        end else if (i_capture_lo) begin
            if (!w_q) begin
                a_reg <= {8'h00, off_q[0] ? i_data[15:8] : i_data[7:0]};
            end else if (off_q[0]) begin
                a_reg[7:0] <= i_data[15:8];     // Odd word, low half first
                off_q      <= off_q + 16'd1;    // Second read at offset + 1
            end else begin
                a_reg <= i_data;
            end
        end else if (i_capture_hi) begin
            a_reg[15:8] <= i_data[7:0];
        end
    end

    assign o_data_addr = phys_addr(seg_q, off_q);
    assign o_need_wide = w_q & off_q[0];
    assign o_op1       = d_q ? b_reg : a_reg;     // d swaps the pair
    assign o_op2       = d_q ? a_reg : b_reg;

endmodule

// File: hw/frontend_fsm.sv
`timescale 1ns/1ps

module frontend_fsm #(
    parameter fe_pkg::word_t RESET_IP = fe_pkg::DEF_RESET_IP
) (
    input  logic             clock,
    input  logic             i_rst_n,
    input  logic             i_full,
    input  logic             i_need_wide,
    input  fe_pkg::paddr_t   i_fetch_addr,
    input  fe_pkg::paddr_t   i_data_addr,
    input  logic [7:0]       i_queue_opcode,
    decode_if.user           dec,
    output logic             o_load,
    output logic             o_shift,
    output fe_pkg::word_t    o_refill_ptr,
    output logic             o_override,
    output fe_pkg::seg_sel_t o_override_sel,
    output logic             o_latch,
    output logic             o_capture_lo,
    output logic             o_capture_hi,
    output fe_pkg::paddr_t   o_addr,
    output logic             o_issue,
    output logic [7:0]       o_issue_opcode,
    output fe_pkg::len_t     o_issue_len,
    output fe_pkg::word_t    o_issue_ip
);
    import fe_pkg::*;

    fe_state_t state;
    word_t     ip;              // Offset of queue head

    assign o_load       = (state == FETCH) && !i_full;
    assign o_shift      = (state == DECODE);
    assign o_latch      = (state == DECODE) && !dec.has_prefix;
    assign o_capture_lo = (state == READ_DATA);
    assign o_capture_hi = (state == READ_DATA_WIDE);
    assign o_issue      = (state == ISSUE);

    // Refetch resumes six bytes past the old head
    assign o_refill_ptr = o_shift ? ip + 16'(QUEUE_BYTES) : ip;
    assign o_addr       = (o_capture_lo || o_capture_hi) ? i_data_addr : i_fetch_addr;

    // ----------------------------------------
    // State machine
    // ----------------------------------------
    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state          <= FETCH;
            ip             <= RESET_IP;
            o_override     <= 1'b0;
            o_override_sel <= SEG_DS;
            o_issue_opcode <= 8'h00;
            o_issue_len    <= 3'd1;
            o_issue_ip     <= RESET_IP;
        end else begin
            case (state)
                FETCH: begin
                    if (i_full) begin
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    ip <= ip + 16'(dec.length);
                    if (dec.has_prefix) begin
                        if (dec.is_override) begin
                            o_override     <= 1'b1;     // Held until issue
                            o_override_sel <= dec.override_sel;
                        end
                        state <= FETCH;
                    end else begin
                        o_issue_opcode <= i_queue_opcode;
                        o_issue_len    <= dec.length;
                        o_issue_ip     <= ip;           // Past any prefixes
                        if (dec.has_modrm && dec.modrm[7:6] != 2'b11) begin
                            state <= READ_DATA;
                        end else begin
                            state <= ISSUE;
                        end
                    end
                end
                READ_DATA:      state <= i_need_wide ? READ_DATA_WIDE : ISSUE;
                READ_DATA_WIDE: state <= ISSUE;
                ISSUE: begin
                    o_override <= 1'b0;
                    state      <= FETCH;
                end
                default:        state <= FETCH;
            endcase
        end
    end

endmodule

// File: hw/frontend_top.sv
`timescale 1ns/1ps

module frontend_top #(
    parameter fe_pkg::word_t RESET_CS = fe_pkg::DEF_RESET_CS,
    parameter fe_pkg::word_t RESET_IP = fe_pkg::DEF_RESET_IP
) (
    input  logic             clock,
    input  logic             i_rst_n,
    input  fe_pkg::word_t    i_data,
    input  logic             i_reg_we,
    input  fe_pkg::reg_idx_t i_reg_sel,
    input  fe_pkg::word_t    i_reg_wdata,
    output fe_pkg::paddr_t   o_addr,
    output logic             o_issue,
    output logic [7:0]       o_issue_opcode,
    output fe_pkg::len_t     o_issue_len,
    output fe_pkg::word_t    o_issue_ip,
    output fe_pkg::word_t    o_op1,
    output fe_pkg::word_t    o_op2
);
    import fe_pkg::*;

    word_t                    gpr [8];
    word_t                    seg [6];
    logic [8*QUEUE_BYTES-1:0] queue;
    logic                     full;
    logic                     need_wide;
    logic                     load;
    logic                     shift;
    logic                     latch;
    logic                     capture_lo;
    logic                     capture_hi;
    logic                     override;
    seg_sel_t                 override_sel;
    word_t                    refill_ptr;
    paddr_t                   fetch_addr;
    paddr_t                   data_addr;

    decode_if dec_bus ();

    reg_file #(.RESET_CS(RESET_CS)) reg_file_inst (
        .clock   (clock),
        .i_rst_n (i_rst_n),
        .i_we    (i_reg_we),
        .i_sel   (i_reg_sel),
        .i_wdata (i_reg_wdata),
        .o_gpr   (gpr),
        .o_seg   (seg)
    );

    fetch_queue fetch_queue_inst (
        .clock        (clock),
        .i_rst_n      (i_rst_n),
        .i_load       (load),
        .i_shift      (shift),
        .i_length     (dec_bus.length),
        .i_refill_ptr (refill_ptr),
        .i_cs         (seg[SEG_CS]),
        .i_data       (i_data),
        .o_queue      (queue),
        .o_full       (full),
        .o_fetch_addr (fetch_addr)
    );

    insn_decoder insn_decoder_inst (
        .i_queue (queue),
        .dec     (dec_bus.dec)
    );

    operand_unit operand_unit_inst (
        .clock          (clock),
        .i_rst_n        (i_rst_n),
        .i_gpr          (gpr),
        .i_seg          (seg),
        .i_override     (override),
        .i_override_sel (override_sel),
        .i_queue        (queue),
        .i_latch        (latch),
        .i_capture_lo   (capture_lo),
        .i_capture_hi   (capture_hi),
        .i_data         (i_data),
        .dec            (dec_bus.user),
        .o_data_addr    (data_addr),
        .o_need_wide    (need_wide),
        .o_op1          (o_op1),
        .o_op2          (o_op2)
    );

    frontend_fsm #(.RESET_IP(RESET_IP)) frontend_fsm_inst (
        .clock          (clock),
        .i_rst_n        (i_rst_n),
        .i_full         (full),
        .i_need_wide    (need_wide),
        .i_fetch_addr   (fetch_addr),
        .i_data_addr    (data_addr),
        .i_queue_opcode (queue[7:0]),
        .dec            (dec_bus.user),
        .o_load         (load),
        .o_shift        (shift),
        .o_refill_ptr   (refill_ptr),
        .o_override     (override),
        .o_override_sel (override_sel),
        .o_latch        (latch),
        .o_capture_lo   (capture_lo),
        .o_capture_hi   (capture_hi),
        .o_addr         (o_addr),
        .o_issue        (o_issue),
        .o_issue_opcode (o_issue_opcode),
        .o_issue_len    (o_issue_len),
        .o_issue_ip     (o_issue_ip)
    );

endmodule

// File: verif/frontend_properties.sv
`timescale 1ns/1ps

module frontend_properties (
    input logic           clock,
    input logic           i_rst_n,
    input logic           i_issue,
    input fe_pkg::len_t   i_issue_len,
    input fe_pkg::paddr_t i_addr
);

    logic violation;    // Sticky, watched from the testbench

    initial violation = 1'b0;

    // ----------------------------------------
    // Issue protocol
    // ----------------------------------------
    issue_one_cycle: assert property (@(posedge clock) disable iff (!i_rst_n)
        i_issue |=> !i_issue) else begin
        $error("issue strobe held for two cycles");
        violation = 1'b1;
    end

    issue_len_range: assert property (@(posedge clock) disable iff (!i_rst_n)
        (i_issue_len >= 3'd1) && (i_issue_len <= 3'd6)) else begin
        $error("issue length outside 1..6");
        violation = 1'b1;
    end

    // No disable here, reset is the point
    issue_quiet_in_reset: assert property (@(posedge clock)
        !i_rst_n |-> !i_issue) else begin
        $error("issue strobe during reset");
        violation = 1'b1;
    end

    // 20-bit bus, so only an unknown bit can leave the 1 MB space
    addr_known: assert property (@(posedge clock) disable iff (!i_rst_n)
        !$isunknown(i_addr)) else begin
        $error("bus address unknown");
        violation = 1'b1;
    end

endmodule

bind frontend_top frontend_properties frontend_properties_inst (
    .clock       (clock),
    .i_rst_n     (i_rst_n),
    .i_issue     (o_issue),
    .i_issue_len (o_issue_len),
    .i_addr      (o_addr)
);

// File: verif/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;
    import fe_pkg::*;

    localparam word_t RESET_CS      = 16'h0100;
    localparam word_t RESET_IP      = 16'h0000;
    localparam int    ISSUE_TIMEOUT = 64;       // Cycles allowed per instruction

    logic        clock;
    logic        i_rst_n;
    word_t       i_data;
    logic        i_reg_we;
    reg_idx_t    i_reg_sel;
    word_t       i_reg_wdata;
    paddr_t      o_addr;
    logic        o_issue;
    logic [7:0]  o_issue_opcode;
    len_t        o_issue_len;
    word_t       o_issue_ip;
    word_t       o_op1;
    word_t       o_op2;

    logic [7:0]  mem [0:(1 << ADDR_W) - 1];    // Whole 1 MB space
    word_t       gpr_model [8];
    word_t       seg_model [6];                // ES CS SS DS FS GS
    word_t       pc;                           // Code offset of next byte
    logic [31:0] seed;

    // Expected issue stream, one entry per instruction
    logic [7:0]  exp_opcode [$];
    len_t        exp_len [$];
    word_t       exp_ip [$];
    logic        exp_check [$];
    word_t       exp_op1 [$];
    word_t       exp_op2 [$];

    initial clock = 1'b0;
    always #2 clock = ~clock;                  // 4 ns period

    // Even-aligned word, low byte from the even address
    assign i_data = {mem[{o_addr[19:1], 1'b1}], mem[{o_addr[19:1], 1'b0}]};

    frontend_top #(.RESET_CS(RESET_CS), .RESET_IP(RESET_IP)) frontend_top_inst (
        .clock          (clock),
        .i_rst_n        (i_rst_n),
        .i_data         (i_data),
        .i_reg_we       (i_reg_we),
        .i_reg_sel      (i_reg_sel),
        .i_reg_wdata    (i_reg_wdata),
        .o_addr         (o_addr),
        .o_issue        (o_issue),
        .o_issue_opcode (o_issue_opcode),
        .o_issue_len    (o_issue_len),
        .o_issue_ip     (o_issue_ip),
        .o_op1          (o_op1),
        .o_op2          (o_op2)
    );

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic word_t lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[31:16];
    endfunction

    function automatic paddr_t seg_off_addr(word_t seg, word_t off);
        return paddr_t'((32'(seg) * 32'd16 + 32'(off)) % 32'h0010_0000);
    endfunction

    // Every address bit feeds the pattern
    function automatic logic [7:0] fill_byte(paddr_t a);
        return a[7:0] ^ {a[11:8], a[15:12]} ^ {a[19:16], 4'h9};
    endfunction

    function automatic word_t reg_value(logic [2:0] idx, logic w);
        if (w) begin
            return gpr_model[idx];
        end
        return idx[2] ? {8'h00, gpr_model[idx[1:0]][15:8]} : {8'h00, gpr_model[idx[1:0]][7:0]};
    endfunction

    function automatic int imm_count(logic [7:0] op);
        if (op[7:2] == 6'b1000_00 || op[7:1] == 7'b1100_011) begin
            return int'(op[0]) + 1;            // 80-83, C6-C7
        end
        return 0;
    endfunction

    function automatic int prefix_segment(logic [7:0] pfx);
        case (pfx)
            8'h26:   return 0;
            8'h2E:   return 1;
            8'h36:   return 2;
            8'h64:   return 4;
            8'h65:   return 5;
            default: return 3;
        endcase
    endfunction

    // ----------------------------------------
    // Program builder
    // ----------------------------------------
    task automatic put_byte(input logic [7:0] b);
        mem[seg_off_addr(RESET_CS, pc)] = b;
        pc = pc + 16'd1;
    endtask

    task automatic push_expect(input logic [7:0] op, input int len, input word_t ip,
                               input logic chk, input word_t a, input word_t b);
        exp_opcode.push_back(op);
        exp_len.push_back(len_t'(len));
        exp_ip.push_back(ip);
        exp_check.push_back(chk);
        exp_op1.push_back(op[1] ? b : a);      // d bit swaps r/m and reg
        exp_op2.push_back(op[1] ? a : b);
    endtask

    task automatic put_imm(input logic [7:0] op);
        word_t r;
        for (int i = 0; i < imm_count(op); i++) begin
            r = lcg_next();
            put_byte(r[7:0]);
        end
    endtask

    task automatic emit_single(input logic [7:0] op);
        push_expect(op, 1, pc, 1'b0, '0, '0);
        put_byte(op);
    endtask

    task automatic emit_reg(input logic [7:0] op, input logic [2:0] rg, input logic [2:0] rm);
        word_t ip_op;
        ip_op = pc;
        put_byte(op);
        put_byte({2'b11, rg, rm});
        put_imm(op);
        push_expect(op, 2 + imm_count(op), ip_op, op < 8'h04,
                    reg_value(rm, op[0]), reg_value(rg, op[0]));
    endtask

    // p picks offset parity, neg forces a negative disp8
    task automatic emit_mem(input logic [7:0] pfx, input logic [7:0] op, input logic [1:0] md,
                            input logic [2:0] rm, input logic [2:0] rg, input logic p,
                            input logic neg);
        word_t  base;
        word_t  disp;
        word_t  off;
        word_t  mem_val;
        word_t  ip_op;
        int     seg_i;
        int     disp_n;
        paddr_t a0;
        case (rm)
            3'd0:    base = gpr_model[3] + gpr_model[6];       // bx+si
            3'd3:    base = gpr_model[5] + gpr_model[7];       // bp+di
            3'd6:    base = (md == 2'b00) ? 16'h0000 : gpr_model[5];
            default: base = gpr_model[3];
        endcase
        disp   = lcg_next();
        disp_n = 2;
        if (md == 2'b01) begin
            disp   = {{8{neg}}, neg, disp[6:1], p ^ base[0]};
            disp_n = 1;
        end else if (md == 2'b00 && rm != 3'd6) begin
            disp   = '0;
            disp_n = 0;
        end else begin
            disp[0] = p ^ base[0];
        end
        off   = base + disp;
        seg_i = (rm == 3'd2 || rm == 3'd3 || (rm == 3'd6 && md != 2'b00)) ? 2 : 3;
        if (pfx != 8'h00) begin
            seg_i = prefix_segment(pfx);
            put_byte(pfx);
        end
        ip_op = pc;                             // Issue IP skips the prefix
        put_byte(op);
        put_byte({md, rg, rm});
        for (int i = 0; i < disp_n; i++) begin
            put_byte(disp[8*i +: 8]);
        end
        put_imm(op);
        a0 = seg_off_addr(seg_model[seg_i], off);
        if (op[0]) begin
            mem_val = {fill_byte(seg_off_addr(seg_model[seg_i], off + 16'd1)), fill_byte(a0)};
        end else begin
            mem_val = {8'h00, fill_byte(a0)};
        end
        push_expect(op, 2 + disp_n + imm_count(op), ip_op, op < 8'h04,
                    mem_val, reg_value(rg, op[0]));
    endtask

    task automatic build_program();
        // Leading one-byte opcodes cover the register preload
        repeat (6) emit_single(8'h90);
        emit_single(8'h0F);
        emit_single(8'h90);
        emit_single(8'h0F);
        emit_reg(8'h00, 3'd5, 3'd1);            // CL, CH
        emit_reg(8'h01, 3'd2, 3'd6);
        emit_reg(8'h02, 3'd4, 3'd3);            // AH, BL swapped
        emit_reg(8'h03, 3'd7, 3'd0);
        emit_mem(8'h00, 8'h02, 2'b01, 3'd0, 3'd1, 1'b1, 1'b1);
        emit_mem(8'h00, 8'h01, 2'b01, 3'd0, 3'd2, 1'b0, 1'b0);
        emit_mem(8'h00, 8'h03, 2'b01, 3'd0, 3'd3, 1'b1, 1'b1);
        emit_mem(8'h00, 8'h00, 2'b01, 3'd3, 3'd4, 1'b0, 1'b0);   // SS default
        emit_mem(8'h00, 8'h03, 2'b01, 3'd3, 3'd5, 1'b0, 1'b1);
        emit_mem(8'h00, 8'h01, 2'b01, 3'd3, 3'd6, 1'b1, 1'b0);
        emit_mem(8'h00, 8'h02, 2'b00, 3'd6, 3'd7, 1'b1, 1'b0);   // Direct
        emit_mem(8'h00, 8'h03, 2'b00, 3'd6, 3'd0, 1'b0, 1'b0);
        emit_mem(8'h00, 8'h01, 2'b00, 3'd6, 3'd1, 1'b1, 1'b0);
        emit_mem(8'h26, 8'h03, 2'b00, 3'd6, 3'd2, 1'b1, 1'b0);   // ES override
        emit_mem(8'h64, 8'h01, 2'b01, 3'd3, 3'd3, 1'b1, 1'b1);   // FS over SS
        emit_reg(8'h80, 3'd0, 3'd1);
        emit_reg(8'h81, 3'd5, 3'd2);
        emit_reg(8'h83, 3'd7, 3'd2);
        emit_mem(8'h00, 8'h82, 2'b01, 3'd0, 3'd0, 1'b0, 1'b0);
        emit_mem(8'h00, 8'hC6, 2'b00, 3'd6, 3'd0, 1'b0, 1'b0);
        emit_mem(8'h00, 8'hC7, 2'b10, 3'd7, 3'd0, 1'b1, 1'b0);   // Six bytes
        emit_single(8'h90);
    endtask

    // ----------------------------------------
    // Drivers and checkers
    // ----------------------------------------
    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic load_registers();
        for (int i = 0; i < 14; i++) begin
            if (i != 9) begin                   // CS stays at reset value
                @(posedge clock);
                #1;
                i_reg_we    = 1'b1;
                i_reg_sel   = reg_idx_t'(i);
                i_reg_wdata = (i < 8) ? gpr_model[i] : seg_model[i - 8];
            end
        end
        @(posedge clock);
        #1;
        i_reg_we = 1'b0;
    endtask

    task automatic wait_for_issue();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > ISSUE_TIMEOUT) begin
                $display("Timed out waiting for an instruction to issue");
                $display("Simulation failed");
                $fatal(1);
            end
        end while (!o_issue);
    endtask

    task automatic check_issues();
        for (int n = 0; n < exp_ip.size(); n++) begin
            wait_for_issue();
            assert (o_issue_ip == exp_ip[n])
                else report_mismatch("issue ip", o_issue_ip, exp_ip[n]);
            assert (o_issue_opcode == exp_opcode[n])
                else report_mismatch("issue opcode", o_issue_opcode, exp_opcode[n]);
            assert (o_issue_len == exp_len[n])
                else report_mismatch("issue length", o_issue_len, exp_len[n]);
            if (exp_check[n]) begin
                assert (o_op1 == exp_op1[n]) else report_mismatch("op1", o_op1, exp_op1[n]);
                assert (o_op2 == exp_op2[n]) else report_mismatch("op2", o_op2, exp_op2[n]);
            end
        end
    endtask

    // Bound checker raises a sticky flag
    always @(negedge clock) begin
        if (frontend_top_inst.frontend_properties_inst.violation === 1'b1) begin
            $display("A bound protocol assertion fired");
            $display("Simulation failed");
            $fatal(1);
        end
    end

    initial begin
        i_rst_n     = 1'b0;
        i_reg_we    = 1'b0;
        i_reg_sel   = '0;
        i_reg_wdata = '0;
        seed        = 32'd29994;
        pc          = RESET_IP;
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            mem[a] = fill_byte(paddr_t'(a));
        end
        for (int i = 0; i < 8; i++) begin
            gpr_model[i] = lcg_next();
        end
        seg_model = '{16'h8000, RESET_CS, 16'h6000, 16'h4000, 16'hA000, 16'hC000};
        build_program();

        repeat (5) @(posedge clock);
        #1;
        i_rst_n = 1'b1;
        @(negedge clock);                       // Before the first fetch edge
        assert (!o_issue) else report_mismatch("issue after reset", o_issue, 0);
        assert (o_addr == seg_off_addr(RESET_CS, RESET_IP))
            else report_mismatch("first fetch address", o_addr,
                                 seg_off_addr(RESET_CS, RESET_IP));

        fork
            load_registers();
            check_issues();
        join

        if (frontend_top_inst.frontend_properties_inst.violation === 1'b1) begin
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: list.f
hw/fe_pkg.sv
hw/decode_if.sv
hw/reg_file.sv
hw/fetch_queue.sv
hw/insn_decoder.sv
hw/operand_unit.sv
hw/frontend_fsm.sv
hw/frontend_top.sv
verif/frontend_properties.sv
verif/tb_frontend.sv
